// ==== files.f ====
verilog/dpb_ppfifo_pkg.sv
verilog/dpb.sv
verilog/adapter_dpb_ppfifo.sv
verilog/ppfifo.sv
verilog/dpb_ppfifo_top.sv
verif/tb_dpb_ppfifo.sv

// ==== verif/dpb_ppfifo_vectors.txt ====
# Bridge vectors, one command per line: cmd a b c, all fields hex
# W addr data | R addr data | V addr count | U count wait | D count | I | P words start cancel_after | C | N reads
W 05 deadbeef 0
R 05 deadbeef 0
W 06 0badf00d 0
R 06 0badf00d 0
W 05 12345678 0
R 05 12345678 0
R 06 0badf00d 0
P 10 0 0
N 1 0 0
V 0 10 0
U 10 1 0
D 10 0 0
U 10 1 0
U 10 1 0
U 10 0 0
D 10 0 0
I 0 0 0
D 10 0 0
D 10 0 0
P 8 1badcafe 0
N 2 0 0
V 0 10 0
P 10 0 5
N 0 0 0
V 0 10 0
P c 0 0
N 1 0 0
C 0 0 0
N 0 0 0
W 00 a0a0a0a0 0
W 0f 5f5f5f5f 0
U 10 1 0
D 10 0 0
R 00 a0a0a0a0 0
R 0f 5f5f5f5f 0

// ==== verif/tb_dpb_ppfifo.sv ====
// Buffer-to-stream bridge testbench
// Runs file vectors against the top level, with an inbound source model
// and a shadow copy of the block RAM
`default_nettype none

module tb_dpb_ppfifo
  import dpb_ppfifo_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned HS_LIMIT    = 1000;
  localparam int unsigned LINE_CYCLES = 200;
  localparam logic [31:0] LCG_SEED    = 32'h7576_22f9;

  logic                  clk;
  logic                  rst;
  logic                  i_bram_we;
  logic [MEM_DEPTH-1:0]  i_bram_addr;
  logic [DATA_WIDTH-1:0] i_bram_din;
  logic [DATA_WIDTH-1:0] o_bram_dout;
  logic                  o_bram_valid;
  logic                  i_ppfifo_2_mem_en;
  logic                  i_mem_2_ppfifo_stb;
  logic                  i_cancel_write_stb;
  logic [31:0]           o_num_reads;
  logic                  o_idle;
  logic                  i_in_read_ready;
  logic [SIZE_WIDTH-1:0] i_in_read_size;
  logic [DATA_WIDTH-1:0] i_in_read_data;
  logic                  o_in_read_activate;
  logic                  o_in_read_stb;
  logic                  o_out_read_ready;
  logic [SIZE_WIDTH-1:0] o_out_read_size;
  logic [DATA_WIDTH-1:0] o_out_read_data;
  logic                  i_out_read_activate;
  logic                  i_out_read_stb;

  logic [DATA_WIDTH-1:0] shadow [MEM_SIZE];
  logic [DATA_WIDTH-1:0] out_q [$];
  logic [7:0]            cmd_q [$];
  logic [31:0]           a_q [$];
  logic [31:0]           b_q [$];
  logic [31:0]           c_q [$];
  logic [31:0]           lcg_state;
  int unsigned           errors;
  int unsigned           checks;
  bit                    loaded;

  dpb_ppfifo_top dut_i (
    .clk                 (clk),
    .rst                 (rst),
    .i_bram_we           (i_bram_we),
    .i_bram_addr         (i_bram_addr),
    .i_bram_din          (i_bram_din),
    .o_bram_dout         (o_bram_dout),
    .o_bram_valid        (o_bram_valid),
    .i_ppfifo_2_mem_en   (i_ppfifo_2_mem_en),
    .i_mem_2_ppfifo_stb  (i_mem_2_ppfifo_stb),
    .i_cancel_write_stb  (i_cancel_write_stb),
    .o_num_reads         (o_num_reads),
    .o_idle              (o_idle),
    .i_in_read_ready     (i_in_read_ready),
    .i_in_read_size      (i_in_read_size),
    .i_in_read_data      (i_in_read_data),
    .o_in_read_activate  (o_in_read_activate),
    .o_in_read_stb       (o_in_read_stb),
    .o_out_read_ready    (o_out_read_ready),
    .o_out_read_size     (o_out_read_size),
    .o_out_read_data     (o_out_read_data),
    .i_out_read_activate (i_out_read_activate),
    .i_out_read_stb      (i_out_read_stb)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected)
    else begin
      $display("Error: %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_waited(input string what, input int waited);
    assert (waited < HS_LIMIT)
    else begin
      $display("Timed out waiting for %s", what);
      errors++;
    end
  endtask

  // Comment lines start with #, data lines hold a command letter and 3 hex fields
  task automatic load_vectors();
    int fd;
    int code;
    int ch;
    logic [7:0]  cmd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    fd = $fopen("verif/dpb_ppfifo_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file");
      errors++;
    end else begin
      while ($fscanf(fd, " %c", cmd) == 1) begin
        if (cmd == "#") begin
          do begin
            ch = $fgetc(fd);
          end while (ch != "\n" && ch != -1);
        end else begin
          code = $fscanf(fd, "%h %h %h", a, b, c);
          if (code != 3) begin
            $display("Vector line for command %c is malformed", cmd);
            errors++;
          end else begin
            cmd_q.push_back(cmd);
            a_q.push_back(a);
            b_q.push_back(b);
            c_q.push_back(c);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    i_bram_we   = 1'b1;
    i_bram_addr = addr[MEM_DEPTH-1:0];
    i_bram_din  = data;
    shadow[addr[MEM_DEPTH-1:0]] = data;
    @(negedge clk);
    i_bram_we = 1'b0;
  endtask

  task automatic read_word(input logic [31:0] addr, input logic [31:0] expected);
    int    waited;
    string name;
    name = $sformatf("read %02h", addr[MEM_DEPTH-1:0]);
    if (i_bram_addr != addr[MEM_DEPTH-1:0]) begin
      i_bram_addr = addr[MEM_DEPTH-1:0];
      #10;
      // Valid must drop as soon as the address moves
      check_value({name, " valid drop"}, 32'd0, o_bram_valid);
    end
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!o_bram_valid && waited < HS_LIMIT);
    check_waited({name, " valid"}, waited);
    check_value(name, expected, o_bram_dout);
  endtask

  task automatic compare_range(input logic [31:0] addr, input logic [31:0] count);
    for (int i = 0; i < count; i++) begin
      read_word(addr + i, shadow[MEM_DEPTH'(addr + i)]);
    end
  endtask

  task automatic push_block(input logic [31:0] count, input logic [31:0] wait_flag);
    int waited;
    i_mem_2_ppfifo_stb = 1'b1;
    @(negedge clk);
    i_mem_2_ppfifo_stb = 1'b0;
    for (int i = 0; i < count; i++) begin
      out_q.push_back(shadow[i]);
    end
    if (wait_flag != 0) begin
      waited = 0;
      while (!o_idle && waited < HS_LIMIT) begin
        @(negedge clk);
        waited++;
      end
      check_waited("push to finish", waited);
    end else begin
      // Both banks full, so the push has to stall in setup
      repeat (8) @(negedge clk);
      check_value("push held", 32'd0, o_idle);
    end
  endtask

  task automatic drain_block(input logic [31:0] count);
    int          waited;
    logic [31:0] expected;
    waited = 0;
    while (!o_out_read_ready && waited < HS_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    check_waited("outbound ready", waited);
    check_value("drain size", count, o_out_read_size);
    i_out_read_activate = 1'b1;
    for (int i = 0; i < count; i++) begin
      @(negedge clk);
      expected = (out_q.size() > 0) ? out_q.pop_front() : 'x;
      check_value($sformatf("drain word %0d", i), expected, o_out_read_data);
      i_out_read_stb = 1'b1;
    end
    @(negedge clk);
    i_out_read_stb      = 1'b0;
    i_out_read_activate = 1'b0;
    @(negedge clk);
  endtask

  // Inbound source model, pops one word per strobe seen
  task automatic pull_block(input logic [31:0] n, input logic [31:0] start,
                            input logic [31:0] cancel_after);
    int          pops;
    int          waited;
    logic [31:0] word;
    if (start != 0) begin
      lcg_state = start;
    end
    word              = lcg_next(lcg_state);
    lcg_state         = word;
    i_in_read_size    = n[SIZE_WIDTH-1:0];
    i_in_read_data    = word;
    i_in_read_ready   = 1'b1;
    i_ppfifo_2_mem_en = 1'b1;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!o_in_read_activate && waited < HS_LIMIT);
    check_waited("inbound activate", waited);
    i_in_read_ready = 1'b0;
    pops = 0;
    while (o_in_read_activate && waited < HS_LIMIT) begin
      if (o_in_read_stb) begin
        shadow[pops]   = word;
        pops++;
        word           = lcg_next(word);
        lcg_state      = word;
        i_in_read_data = word;
        if (cancel_after != 0 && pops == cancel_after) begin
          i_cancel_write_stb = 1'b1;
          i_ppfifo_2_mem_en  = 1'b0;
        end
      end
      @(negedge clk);
      waited++;
      i_cancel_write_stb = 1'b0;
    end
    check_waited("inbound deactivate", waited);
    i_ppfifo_2_mem_en = 1'b0;
    if (cancel_after != 0) begin
      check_value("cancel pops", cancel_after, pops);
      check_value("cancel before end", 32'd1, pops < n);
      check_value("cancel reads", 32'd0, o_num_reads);
      check_value("cancel idle", 32'd1, o_idle);
    end else begin
      check_value("pull pops", n, pops);
      check_value("pull idle", 32'd1, o_idle);
    end
  endtask

  task automatic send_cancel();
    i_cancel_write_stb = 1'b1;
    @(negedge clk);
    i_cancel_write_stb = 1'b0;
    check_value("cancel idle", 32'd1, o_idle);
    check_value("cancel activate", 32'd0, o_in_read_activate);
    check_value("cancel reads", 32'd0, o_num_reads);
  endtask

  task automatic await_idle();
    int waited;
    waited = 0;
    while (!o_idle && waited < HS_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    check_waited("idle", waited);
  endtask

  initial begin
    clk                 = 1'b0;
    rst                 = 1'b1;
    i_bram_we           = 1'b0;
    i_bram_addr         = '0;
    i_bram_din          = '0;
    i_ppfifo_2_mem_en   = 1'b0;
    i_mem_2_ppfifo_stb  = 1'b0;
    i_cancel_write_stb  = 1'b0;
    i_in_read_ready     = 1'b0;
    i_in_read_size      = '0;
    i_in_read_data      = '0;
    i_out_read_activate = 1'b0;
    i_out_read_stb      = 1'b0;
    errors              = 0;
    checks              = 0;
    lcg_state           = LCG_SEED;
    load_vectors();
    loaded = 1'b1;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_value("reset idle", 32'd1, o_idle);
    check_value("reset activate", 32'd0, o_in_read_activate);
    check_value("reset reads", 32'd0, o_num_reads);
    check_value("reset out ready", 32'd0, o_out_read_ready);
    for (int i = 0; i < cmd_q.size(); i++) begin
      case (cmd_q[i])
        "W": write_word(a_q[i], b_q[i]);
        "R": read_word(a_q[i], b_q[i]);
        "V": compare_range(a_q[i], b_q[i]);
        "U": push_block(a_q[i], b_q[i]);
        "D": drain_block(a_q[i]);
        "I": await_idle();
        "P": pull_block(a_q[i], b_q[i], c_q[i]);
        "C": send_cancel();
        "N": check_value("pull count", a_q[i], o_num_reads);
        default: begin
          $display("Unknown vector command %c", cmd_q[i]);
          errors++;
        end
      endcase
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog sized from the vector count
  initial begin
    wait (loaded);
    repeat (cmd_q.size() * LINE_CYCLES + 20) @(posedge clk);
    $display("Watchdog stopped the run after %0d vector lines, errors: %0d",
             cmd_q.size(), errors);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/adapter_dpb_ppfifo.sv ====
// Block RAM to ping-pong FIFO adapter
// Tracks when user read data has settled, and moves blocks between the
// RAM's second port and the outbound and inbound ping-pong handshakes
`default_nettype none

module adapter_dpb_ppfifo
  import dpb_ppfifo_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst,

  // Commands
  input  wire                   i_ppfifo_2_mem_en,
  input  wire                   i_mem_2_ppfifo_stb,
  input  wire                   i_cancel_write_stb,
  output logic [31:0]           o_num_reads,
  output logic                  o_idle,

  // User address watch
  input  wire  [MEM_DEPTH-1:0]  i_bram_addr,
  output logic                  o_bram_valid,

  // Outbound ping-pong write side
  input  wire  [1:0]            i_write_ready,
  output logic [1:0]            o_write_activate,
  input  wire  [SIZE_WIDTH-1:0] i_write_size,
  output logic                  o_write_stb,

  // Inbound ping-pong read side
  input  wire                   i_read_ready,
  output logic                  o_read_activate,
  input  wire  [SIZE_WIDTH-1:0] i_read_size,
  input  wire  [DATA_WIDTH-1:0] i_read_data,
  output logic                  o_read_stb,

  // RAM port B
  output logic                  o_mem_we,
  output logic [MEM_DEPTH-1:0]  o_mem_addr,
  output logic [DATA_WIDTH-1:0] o_mem_din
);

  localparam logic [1:0] S_IDLE     = 2'd0;
  localparam logic [1:0] S_WR_SETUP = 2'd1;
  localparam logic [1:0] S_WRITE    = 2'd2;
  localparam logic [1:0] S_READ     = 2'd3;

  logic [1:0]            state;
  logic [SIZE_WIDTH-1:0] count;
  logic [MEM_DEPTH-1:0]  prev_addr;
  logic [WAIT_WIDTH-1:0] wait_cnt;

  assign o_idle    = (state == S_IDLE);
  // Inbound word goes straight to port B, o_mem_we picks the cycle
  assign o_mem_din = i_read_data;

  // Valid once the address has held for MEM_WAIT edges
  assign o_bram_valid = (prev_addr == i_bram_addr) &&
                        (wait_cnt == WAIT_WIDTH'(MEM_WAIT));

  always_ff @(posedge clk) begin
    if (rst) begin
      prev_addr <= '0;
      wait_cnt  <= WAIT_WIDTH'(MEM_WAIT);
    end else if (prev_addr != i_bram_addr) begin
      prev_addr <= i_bram_addr;
      wait_cnt  <= '0;
    end else if (wait_cnt < WAIT_WIDTH'(MEM_WAIT)) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // Transfer FSM; strobes default low every cycle
  always_ff @(posedge clk) begin
    o_write_stb <= 1'b0;
    o_read_stb  <= 1'b0;
    o_mem_we    <= 1'b0;
    if (rst || i_cancel_write_stb) begin
      state            <= S_IDLE;
      o_write_activate <= 2'b00;
      o_read_activate  <= 1'b0;
      o_num_reads      <= '0;
      count            <= '0;
      o_mem_addr       <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          o_write_activate <= 2'b00;
          o_read_activate  <= 1'b0;
          count            <= '0;
          o_mem_addr       <= '0;
          if (i_mem_2_ppfifo_stb) begin
            state <= S_WR_SETUP;
          end else if (i_ppfifo_2_mem_en && i_read_ready) begin
            o_read_activate <= 1'b1;
            state           <= S_READ;
          end
        end
        S_WR_SETUP: begin
          // Wait here until a bank frees, bank 0 first
          if (i_write_ready != 2'b00) begin
            if (i_write_ready[0]) begin
              o_write_activate <= 2'b01;
            end else begin
              o_write_activate <= 2'b10;
            end
            state <= S_WRITE;
          end
        end
        S_WRITE: begin
          // Port B read latency lines dout up with the strobe
          if (count < i_write_size) begin
            o_write_stb <= 1'b1;
            o_mem_addr  <= o_mem_addr + 1'b1;
            count       <= count + 1'b1;
          end else begin
            o_write_activate <= 2'b00;
            state            <= S_IDLE;
          end
        end
        S_READ: begin
          // Write cycle, then pop cycle, per word
          if (o_mem_we) begin
            o_read_stb <= 1'b1;
            count      <= count + 1'b1;
          end else if (count < i_read_size) begin
            o_mem_we <= 1'b1;
            if (o_read_stb) begin
              o_mem_addr <= o_mem_addr + 1'b1;
            end
          end else begin
            o_num_reads     <= o_num_reads + 32'd1;
            o_read_activate <= 1'b0;
            state           <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // Only one outbound bank is ever claimed
  a_one_bank: assert property (@(posedge clk) disable iff (rst)
    !(&o_write_activate));

  // Inbound pops stay inside the activate window
  a_stb_in_read: assert property (@(posedge clk) disable iff (rst)
    o_read_stb |-> o_read_activate);

endmodule

`default_nettype wire

// ==== verilog/dpb.sv ====
// Dual-port block RAM
// Two independent ports, each with a synchronous write and a registered read
`default_nettype none

module dpb
  import dpb_ppfifo_pkg::*;
(
  input  wire                   clk,

  input  wire                   i_a_we,
  input  wire  [MEM_DEPTH-1:0]  i_a_addr,
  input  wire  [DATA_WIDTH-1:0] i_a_din,
  output logic [DATA_WIDTH-1:0] o_a_dout,

  input  wire                   i_b_we,
  input  wire  [MEM_DEPTH-1:0]  i_b_addr,
  input  wire  [DATA_WIDTH-1:0] i_b_din,
  output logic [DATA_WIDTH-1:0] o_b_dout
);

  logic [DATA_WIDTH-1:0] mem [MEM_SIZE];

  // Both write ports; same-address collisions are left undefined
  always_ff @(posedge clk) begin
    if (i_a_we) begin
      mem[i_a_addr] <= i_a_din;
    end
    if (i_b_we) begin
      mem[i_b_addr] <= i_b_din;
    end
  end

  // Read-first on each port
  always_ff @(posedge clk) begin
    o_a_dout <= mem[i_a_addr];
  end

  always_ff @(posedge clk) begin
    o_b_dout <= mem[i_b_addr];
  end

endmodule

`default_nettype wire

// ==== verilog/dpb_ppfifo_pkg.sv ====
// Buffer-to-stream bridge shared constants
// Data, address, ping-pong bank and read-settle timing values
`default_nettype none

package dpb_ppfifo_pkg;

  // One data word on every path
  localparam int unsigned DATA_WIDTH   = 32;

  // Block RAM address width and word count
  localparam int unsigned MEM_DEPTH    = 8;
  localparam int unsigned MEM_SIZE     = 2 ** MEM_DEPTH;

  // Ping-pong bank address width and words per bank
  localparam int unsigned PPFIFO_DEPTH = 4;
  localparam int unsigned PPFIFO_SIZE  = 2 ** PPFIFO_DEPTH;

  // Transfer size fields on the activate/ready handshakes
  localparam int unsigned SIZE_WIDTH   = 24;

  // Edges the user address must hold before read data counts as settled
  localparam int unsigned MEM_WAIT     = 2;
  localparam int unsigned WAIT_WIDTH   = $clog2(MEM_WAIT + 1);

endpackage

`default_nettype wire

// ==== verilog/dpb_ppfifo_top.sv ====
// Buffer-to-stream bridge top level
// User memory port on RAM port A; adapter moves blocks over port B
// into the outbound ping-pong FIFO or in from the inbound source
`default_nettype none

module dpb_ppfifo_top
  import dpb_ppfifo_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst,

  // User memory port
  input  wire                   i_bram_we,
  input  wire  [MEM_DEPTH-1:0]  i_bram_addr,
  input  wire  [DATA_WIDTH-1:0] i_bram_din,
  output logic [DATA_WIDTH-1:0] o_bram_dout,
  output logic                  o_bram_valid,

  // Commands and status
  input  wire                   i_ppfifo_2_mem_en,
  input  wire                   i_mem_2_ppfifo_stb,
  input  wire                   i_cancel_write_stb,
  output logic [31:0]           o_num_reads,
  output logic                  o_idle,

  // Inbound source read side
  input  wire                   i_in_read_ready,
  input  wire  [SIZE_WIDTH-1:0] i_in_read_size,
  input  wire  [DATA_WIDTH-1:0] i_in_read_data,
  output logic                  o_in_read_activate,
  output logic                  o_in_read_stb,

  // Outbound FIFO read side
  output logic                  o_out_read_ready,
  output logic [SIZE_WIDTH-1:0] o_out_read_size,
  output logic [DATA_WIDTH-1:0] o_out_read_data,
  input  wire                   i_out_read_activate,
  input  wire                   i_out_read_stb
);

  logic [1:0]            write_ready;
  logic [1:0]            write_activate;
  logic [SIZE_WIDTH-1:0] write_size;
  logic                  write_stb;
  logic                  mem_we;
  logic [MEM_DEPTH-1:0]  mem_addr;
  logic [DATA_WIDTH-1:0] mem_din;
  logic [DATA_WIDTH-1:0] mem_dout;

  adapter_dpb_ppfifo adapter_i (
    .clk                (clk),
    .rst                (rst),
    .i_ppfifo_2_mem_en  (i_ppfifo_2_mem_en),
    .i_mem_2_ppfifo_stb (i_mem_2_ppfifo_stb),
    .i_cancel_write_stb (i_cancel_write_stb),
    .o_num_reads        (o_num_reads),
    .o_idle             (o_idle),
    .i_bram_addr        (i_bram_addr),
    .o_bram_valid       (o_bram_valid),
    .i_write_ready      (write_ready),
    .o_write_activate   (write_activate),
    .i_write_size       (write_size),
    .o_write_stb        (write_stb),
    .i_read_ready       (i_in_read_ready),
    .o_read_activate    (o_in_read_activate),
    .i_read_size        (i_in_read_size),
    .i_read_data        (i_in_read_data),
    .o_read_stb         (o_in_read_stb),
    .o_mem_we           (mem_we),
    .o_mem_addr         (mem_addr),
    .o_mem_din          (mem_din)
  );

  dpb dpb_i (
    .clk      (clk),
    .i_a_we   (i_bram_we),
    .i_a_addr (i_bram_addr),
    .i_a_din  (i_bram_din),
    .o_a_dout (o_bram_dout),
    .i_b_we   (mem_we),
    .i_b_addr (mem_addr),
    .i_b_din  (mem_din),
    .o_b_dout (mem_dout)
  );

  // Port B read data is the outbound write word
  ppfifo ppfifo_i (
    .clk              (clk),
    .rst              (rst),
    .o_write_ready    (write_ready),
    .i_write_activate (write_activate),
    .o_write_size     (write_size),
    .i_write_stb      (write_stb),
    .i_write_data     (mem_dout),
    .o_read_ready     (o_out_read_ready),
    .i_read_activate  (i_out_read_activate),
    .o_read_size      (o_out_read_size),
    .i_read_stb       (i_out_read_stb),
    .o_read_data      (o_out_read_data)
  );

endmodule

`default_nettype wire

// ==== verilog/ppfifo.sv ====
// Two-bank ping-pong FIFO
// Writer claims an empty bank with activate, fills it and releases it;
// reader drains full banks in fill order through activate/stb
`default_nettype none

module ppfifo
  import dpb_ppfifo_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst,

  // Write side
  output logic [1:0]            o_write_ready,
  input  wire  [1:0]            i_write_activate,
  output logic [SIZE_WIDTH-1:0] o_write_size,
  input  wire                   i_write_stb,
  input  wire  [DATA_WIDTH-1:0] i_write_data,

  // Read side
  output logic                  o_read_ready,
  input  wire                   i_read_activate,
  output logic [SIZE_WIDTH-1:0] o_read_size,
  input  wire                   i_read_stb,
  output logic [DATA_WIDTH-1:0] o_read_data
);

  localparam logic [1:0] ST_EMPTY = 2'd0;
  localparam logic [1:0] ST_FILL  = 2'd1;
  localparam logic [1:0] ST_FULL  = 2'd2;
  localparam logic [1:0] ST_READ  = 2'd3;

  logic [DATA_WIDTH-1:0] bank_mem [2][PPFIFO_SIZE];
  logic [1:0]            bank_st  [2];
  logic [PPFIFO_DEPTH:0] wr_count [2];
  logic [PPFIFO_DEPTH:0] rd_count;
  logic                  rd_ptr;
  logic                  rd_busy;
  logic                  wr_sel;
  logic                  wr_ok;
  logic                  rd_start;
  logic                  rd_pop;

  assign wr_sel = i_write_activate[1];
  assign wr_ok  = i_write_stb && (i_write_activate != 2'b00) &&
                  (bank_st[wr_sel] == ST_FILL);

  assign o_write_ready[0] = (bank_st[0] == ST_EMPTY);
  assign o_write_ready[1] = (bank_st[1] == ST_EMPTY);
  assign o_write_size     = SIZE_WIDTH'(PPFIFO_SIZE);

  // rd_ptr names the oldest full bank, or the one being read
  assign o_read_ready = !rd_busy && (bank_st[rd_ptr] == ST_FULL);
  assign o_read_size  = SIZE_WIDTH'(wr_count[rd_ptr]);
  assign o_read_data  = bank_mem[rd_ptr][rd_count[PPFIFO_DEPTH-1:0]];

  // A stb in the activation cycle itself also pops
  assign rd_start = i_read_activate && o_read_ready;
  assign rd_pop   = i_read_stb && i_read_activate && (rd_busy || o_read_ready);

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      bank_mem[wr_sel][wr_count[wr_sel][PPFIFO_DEPTH-1:0]] <= i_write_data;
    end
  end

  // Per-bank lifecycle
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2; i++) begin
        bank_st[i]  <= ST_EMPTY;
        wr_count[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        case (bank_st[i])
          ST_EMPTY: begin
            if (i_write_activate[i]) begin
              bank_st[i]  <= ST_FILL;
              wr_count[i] <= '0;
            end
          end
          ST_FILL: begin
            if (!i_write_activate[i]) begin
              // Released with nothing in it
              bank_st[i] <= (wr_count[i] != '0) ? ST_FULL : ST_EMPTY;
            end else if (wr_ok && (wr_sel == 1'(i))) begin
              wr_count[i] <= wr_count[i] + 1'b1;
            end
          end
          ST_FULL: begin
            if (rd_start && (rd_ptr == 1'(i))) begin
              bank_st[i] <= ST_READ;
            end
          end
          default: begin
            if (rd_busy && !i_read_activate && (rd_ptr == 1'(i))) begin
              bank_st[i] <= ST_EMPTY;
            end
          end
        endcase
      end
    end
  end

  // Read pointer and pop count
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr   <= 1'b0;
      rd_busy  <= 1'b0;
      rd_count <= '0;
    end else if (rd_busy && !i_read_activate) begin
      rd_busy  <= 1'b0;
      rd_count <= '0;
      rd_ptr   <= ~rd_ptr;
    end else begin
      if (rd_start) begin
        rd_busy <= 1'b1;
      end
      if (rd_pop) begin
        rd_count <= rd_count + 1'b1;
      end
      // Other bank filled first while this one sits empty
      if ((bank_st[rd_ptr] == ST_EMPTY) && (bank_st[~rd_ptr] == ST_FULL)) begin
        rd_ptr <= ~rd_ptr;
      end
    end
  end

  a_stb_needs_bank: assert property (@(posedge clk) disable iff (rst)
    i_write_stb |-> (i_write_activate != 2'b00));

  a_count_limit: assert property (@(posedge clk) disable iff (rst)
    (wr_count[0] <= PPFIFO_SIZE) && (wr_count[1] <= PPFIFO_SIZE));

endmodule

`default_nettype wire
